/* files.f */
logic/soc_pkg.sv
logic/bus_fsm.sv
logic/sram_store.sv
logic/clint_timer.sv
logic/soc_top.sv
tests/soc_top_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --top-module soc_top_tb -f files.f -o soc_top_tb_sim &&
./obj_dir/soc_top_tb_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

/* tests/soc_top_tb.sv */
`timescale 1ns/1ps

module soc_top_tb;

    import soc_pkg::*;

    localparam int SRAM_WORDS = 64;                         // uut defaults
    localparam int TICK_DIV   = 4;
    localparam int WAIT_MAX   = 50;                         // Per-handshake bound, cycles
    localparam int MAX_CYCLES = 4000;                       // Whole run bound
    localparam logic [ADDR_W-1:0] UNMAPPED = 32'h4000_0000;

    logic              clk;
    logic              rst_n;
    wr_req_t           wr_req;
    logic              wr_valid;
    logic              wr_ready;
    logic [1:0]        b_resp;
    logic              b_valid;
    logic              b_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              ar_valid;
    logic              ar_ready;
    rd_rsp_t           r_rsp;
    logic              r_valid;
    logic              r_ready;
    logic              timer_irq;

    integer            seed = 32'h27b95f2b;
    int                mismatch_cnt = 0;                    // Wrong values
    int                fault_cnt = 0;                       // Handshake problems
    int                cycle_cnt;
    logic [DATA_W-1:0] sram_model [16];                     // Expected words 0..15

    soc_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .b_resp    (b_resp),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .ar_addr   (ar_addr),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r_rsp     (r_rsp),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                             // 40 ns period
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatch_cnt++;
        $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
    endtask

    // Byte merge of a strobed write over an old word
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++)
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        return res;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(negedge clk);
        wr_req.addr = addr;
        wr_req.data = data;
        wr_req.strb = strb;
        wr_valid    = 1'b1;
        n = 0;
        while (!wr_ready && n < WAIT_MAX) begin             // ready is stable here
            @(negedge clk);
            n++;
        end
        if (!wr_ready) begin
            fault_cnt++;
            $display("ERROR: write to %h was never accepted", addr);
        end
        @(negedge clk);                                     // Accepted on the edge just gone
        wr_valid = 1'b0;
        b_ready  = 1'b1;
        n = 0;
        while (!b_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!b_valid) begin
            fault_cnt++;
            $display("ERROR: write to %h got no response", addr);
        end
        resp = b_resp;
        @(negedge clk);                                     // Response taken
        b_ready = 1'b0;
    endtask

    // hold: cycles of r_ready low once r_valid is seen
    task automatic bus_read(input logic [31:0] addr, input int hold, output rd_rsp_t rsp);
        int n;
        rd_rsp_t held;
        @(negedge clk);
        ar_addr  = addr;
        ar_valid = 1'b1;
        n = 0;
        while (!ar_ready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!ar_ready) begin
            fault_cnt++;
            $display("ERROR: read from %h was never accepted", addr);
        end
        @(negedge clk);
        ar_valid = 1'b0;
        n = 0;
        while (!r_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!r_valid) begin
            fault_cnt++;
            $display("ERROR: read from %h got no response", addr);
        end
        held = r_rsp;
        repeat (hold) begin                                 // Stalled master
            @(negedge clk);
            if (r_rsp !== held) report_mismatch("backpressure_hold", held.data, r_rsp.data);
            if (!r_valid || ar_ready || wr_ready) begin
                fault_cnt++;
                $display("ERROR: response dropped or a request channel reopened while stalled");
            end
        end
        r_ready = 1'b1;
        rsp     = r_rsp;
        @(negedge clk);
        r_ready = 1'b0;
    endtask

    task automatic test_reset();
        rd_rsp_t rsp;
        if ({ar_ready, wr_ready, r_valid, b_valid, timer_irq} !== 5'b11000)
            report_mismatch("reset_outputs", 32'h18,
                            32'({ar_ready, wr_ready, r_valid, b_valid, timer_irq}));
        bus_read(CLINT_BASE + 32'h8, 0, rsp);               // mtimecmp low
        if (rsp.data !== 32'hFFFF_FFFF) report_mismatch("reset_cmp_lo", 32'hFFFF_FFFF, rsp.data);
        bus_read(CLINT_BASE + 32'hC, 0, rsp);               // mtimecmp high
        if (rsp.data !== 32'hFFFF_FFFF) report_mismatch("reset_cmp_hi", 32'hFFFF_FFFF, rsp.data);
    endtask

    task automatic test_sram_rw();
        logic [1:0] resp;
        rd_rsp_t rsp;
        for (int i = 0; i < 16; i++) begin
            sram_model[i] = $random(seed);
            bus_write(SRAM_BASE + 32'(i * 4), sram_model[i], 4'hF, resp);
            if (resp !== RESP_OKAY) report_mismatch("sram_write_resp", 0, 32'(resp));
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(SRAM_BASE + 32'(i * 4), 0, rsp);
            if (rsp.data !== sram_model[i]) report_mismatch("sram_read", sram_model[i], rsp.data);
            if (rsp.resp !== RESP_OKAY) report_mismatch("sram_read_resp", 0, 32'(rsp.resp));
        end
        // One memory size up lands on the same word
        bus_read(SRAM_BASE + 32'(3 * 4 + SRAM_WORDS * 4), 0, rsp);
        if (rsp.data !== sram_model[3]) report_mismatch("sram_alias", sram_model[3], rsp.data);
    endtask

    task automatic test_strobes();
        logic [31:0] addr;
        logic [31:0] old_w;
        logic [31:0] new_w;
        logic [31:0] exp;
        logic [1:0]  resp;
        rd_rsp_t     rsp;
        addr  = SRAM_BASE + 32'hC0;                         // Word 48, clear of the others
        old_w = $random(seed);
        new_w = $random(seed);
        bus_write(addr, old_w, 4'hF, resp);
        bus_write(addr, new_w, 4'b0101, resp);
        exp = apply_strobes(old_w, new_w, 4'b0101);
        bus_read(addr, 0, rsp);
        if (rsp.data !== exp) report_mismatch("byte_strobes", exp, rsp.data);
    endtask

    task automatic test_decode_error();
        logic [1:0] resp;
        rd_rsp_t    rsp;
        bus_read(UNMAPPED, 0, rsp);
        if (rsp.resp !== RESP_DECERR) report_mismatch("decerr_read_resp", 3, 32'(rsp.resp));
        if (rsp.data !== '0) report_mismatch("decerr_read_data", 0, rsp.data);
        bus_write(UNMAPPED + 32'h14, 32'hDEAD_BEEF, 4'hF, resp);   // Word 5 if it aliased
        if (resp !== RESP_DECERR) report_mismatch("decerr_write_resp", 3, 32'(resp));
        bus_read(SRAM_BASE + 32'h14, 0, rsp);
        if (rsp.data !== sram_model[5]) report_mismatch("decerr_no_write", sram_model[5], rsp.data);
    endtask

    task automatic test_backpressure();
        rd_rsp_t rsp;
        bus_read(SRAM_BASE + 32'h1C, 10, rsp);              // Word 7, ten stalled cycles
        if (rsp.data !== sram_model[7]) report_mismatch("backpressure_data", sram_model[7], rsp.data);
        if (rsp.resp !== RESP_OKAY) report_mismatch("backpressure_resp", 0, 32'(rsp.resp));
    endtask

    task automatic test_timer();
        logic [31:0] min_next;
        logic [1:0]  resp;
        rd_rsp_t     rsp;
        int          n;
        bus_read(CLINT_BASE, 0, rsp);                       // mtime low
        min_next = rsp.data + 32'(200 / TICK_DIV);          // At least one tick per TICK_DIV
        repeat (200) @(negedge clk);
        bus_read(CLINT_BASE, 0, rsp);
        if (rsp.data < min_next) report_mismatch("mtime_advance", min_next, rsp.data);
        bus_read(CLINT_BASE + 32'h4, 0, rsp);               // mtime high
        if (rsp.data !== '0) report_mismatch("mtime_hi", 0, rsp.data);
        if (timer_irq !== 1'b0) report_mismatch("irq_idle", 0, 32'(timer_irq));
        bus_write(CLINT_BASE + 32'h8, 32'h0, 4'hF, resp);
        bus_write(CLINT_BASE + 32'hC, 32'h0, 4'hF, resp);   // mtimecmp now 0
        n = 0;
        while (!timer_irq && n < 5) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq !== 1'b1) report_mismatch("irq_rise", 1, 32'(timer_irq));
        bus_write(CLINT_BASE + 32'hC, 32'hFFFF_FFFF, 4'hF, resp);
        n = 0;
        while (timer_irq && n < 5) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq !== 1'b0) report_mismatch("irq_fall", 0, 32'(timer_irq));
    endtask

    initial begin
        rst_n    = 1'b0;
        wr_req   = '0;
        wr_valid = 1'b0;
        b_ready  = 1'b0;
        ar_addr  = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        repeat (5) @(negedge clk);                          // Five reset edges
        rst_n = 1'b1;
        test_reset();
        test_sram_rw();
        test_strobes();
        test_decode_error();
        test_backpressure();
        test_timer();
        $display("Done: %0d value mismatches, %0d handshake errors", mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
    parameter int SRAM_WORDS = 64,
    parameter int TICK_DIV   = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  soc_pkg::wr_req_t            wr_req,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    output logic [1:0]                  b_resp,
    output logic                        b_valid,
    input  logic                        b_ready,
    input  logic [soc_pkg::ADDR_W-1:0]  ar_addr,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    output soc_pkg::rd_rsp_t            r_rsp,
    output logic                        r_valid,
    input  logic                        r_ready,
    output logic                        timer_irq
);

    import soc_pkg::*;

    dev_req_t          dev_req;                             // Shared device request
    logic              sram_sel;
    logic              clint_sel;
    logic [DATA_W-1:0] sram_rdata;
    logic [DATA_W-1:0] clint_rdata;

    // Master port to device selects
    bus_fsm u_bus_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req      (wr_req),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .b_resp      (b_resp),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .ar_addr     (ar_addr),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r_rsp       (r_rsp),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .dev_req     (dev_req),
        .sram_sel    (sram_sel),
        .clint_sel   (clint_sel),
        .sram_rdata  (sram_rdata),
        .clint_rdata (clint_rdata)
    );

    // Word memory at 0x8000_0000
    sram_store #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram_store (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (sram_sel),
        .req   (dev_req),
        .rdata (sram_rdata)
    );

    // Machine timer at 0xA000_0040
    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_clint_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (clint_sel),
        .req       (dev_req),
        .rdata     (clint_rdata),
        .timer_irq (timer_irq)
    );

endmodule

/* logic/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
    parameter int TICK_DIV = 4                              // Clocks per mtime increment
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sel,
    input  soc_pkg::dev_req_t           req,
    output logic [soc_pkg::DATA_W-1:0]  rdata,
    output logic                        timer_irq
);

    import soc_pkg::*;

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0]  div_cnt;                             // Prescaler
    logic              tick;                                // mtime advance strobe
    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic [DATA_W-1:0] wmask;                               // Strobes expanded to bits
    logic              wr_en;
    logic              rd_en;

    // Byte strobes to bit mask
    always_comb begin
        for (int b = 0; b < STRB_W; b++)
            wmask[8*b +: 8] = {8{req.strb[b]}};
    end

    assign wr_en = sel && req.wr;
    assign rd_en = sel && !req.wr;
    assign tick  = (div_cnt == DIV_W'(TICK_DIV - 1));

    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old_w,
                                                input logic [DATA_W-1:0] new_w,
                                                input logic [DATA_W-1:0] mask);
        merge = (old_w & ~mask) | (new_w & mask);
    endfunction

    // Prescaler, wraps every TICK_DIV clocks
    always_ff @(posedge clk) begin
        if (!rst_n)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // mtime, a write to one half beats the tick
    always_ff @(posedge clk) begin
        if (!rst_n)
            mtime <= '0;
        else if (wr_en && (req.ofs == MTIME_LO_OFS))
            mtime[31:0] <= merge(mtime[31:0], req.data, wmask);
        else if (wr_en && (req.ofs == MTIME_HI_OFS))
            mtime[63:32] <= merge(mtime[63:32], req.data, wmask);
        else if (tick)
            mtime <= mtime + 64'd1;
    end

    // mtimecmp, all ones keeps the interrupt off
    always_ff @(posedge clk) begin
        if (!rst_n)
            mtimecmp <= '1;
        else if (wr_en && (req.ofs == MTIMECMP_LO_OFS))
            mtimecmp[31:0] <= merge(mtimecmp[31:0], req.data, wmask);
        else if (wr_en && (req.ofs == MTIMECMP_HI_OFS))
            mtimecmp[63:32] <= merge(mtimecmp[63:32], req.data, wmask);
    end

    // Compare registered, one cycle behind
    always_ff @(posedge clk) begin
        if (!rst_n)
            timer_irq <= 1'b0;
        else
            timer_irq <= (mtime >= mtimecmp);
    end

    // Register read port
    always_ff @(posedge clk) begin
        if (!rst_n)
            rdata <= '0;
        else if (rd_en) begin
            case (req.ofs)
                MTIME_LO_OFS:    rdata <= mtime[31:0];
                MTIME_HI_OFS:    rdata <= mtime[63:32];
                MTIMECMP_LO_OFS: rdata <= mtimecmp[31:0];
                MTIMECMP_HI_OFS: rdata <= mtimecmp[63:32];
                default:         rdata <= '0;               // Unused offsets
            endcase
        end
    end

endmodule

/* logic/sram_store.sv */
`timescale 1ns/1ps

module sram_store #(
    parameter int SRAM_WORDS = 64                           // Power of two
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sel,
    input  soc_pkg::dev_req_t           req,
    output logic [soc_pkg::DATA_W-1:0]  rdata
);

    import soc_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);

    logic [DATA_W-1:0] mem [SRAM_WORDS];                    // Word array
    logic [IDX_W-1:0]  idx;                                 // Aliased word index
    logic              wr_en;
    logic              rd_en;

    // Upper offset bits dropped, region aliases
    assign idx   = req.ofs[IDX_W-1:0];
    assign wr_en = sel && req.wr;
    assign rd_en = sel && !req.wr;

    // Byte-merged write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.strb[b])
                    mem[idx][8*b +: 8] <= req.data[8*b +: 8];   // Strobed byte only
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (!rst_n)
            rdata <= '0;
        else if (rd_en)
            rdata <= mem[idx];                              // Held until next select
    end

endmodule

/* logic/bus_fsm.sv */
`timescale 1ns/1ps

module bus_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  soc_pkg::wr_req_t            wr_req,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    output logic [1:0]                  b_resp,
    output logic                        b_valid,
    input  logic                        b_ready,
    input  logic [soc_pkg::ADDR_W-1:0]  ar_addr,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    output soc_pkg::rd_rsp_t            r_rsp,
    output logic                        r_valid,
    input  logic                        r_ready,
    output soc_pkg::dev_req_t           dev_req,
    output logic                        sram_sel,
    output logic                        clint_sel,
    input  logic [soc_pkg::DATA_W-1:0]  sram_rdata,
    input  logic [soc_pkg::DATA_W-1:0]  clint_rdata
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,                                               // Waiting for a request
        ACCESS,                                             // Device strobed this cycle
        RESP_RD,                                            // Read response out
        RESP_WR                                             // Write response out
    } state_t;

    typedef enum logic [1:0] {
        TGT_NONE,                                           // Unmapped, DECERR
        TGT_SRAM,
        TGT_CLINT
    } tgt_t;

    state_t            state;
    tgt_t              tgt;                                 // Device hit by held request
    dev_req_t          req_q;                               // Held request
    logic              rd_go;                               // Read accepted this edge
    logic              wr_go;                               // Write accepted this edge
    logic [ADDR_W-1:0] acc_addr;                            // Address being accepted
    logic [ADDR_W-1:0] acc_local;                           // Byte address inside region
    logic              sram_hit;
    logic              clint_hit;
    logic [DATA_W-1:0] dev_rdata;                           // Word of recorded target
    logic [RESP_W-1:0] dev_resp;

    // Both request channels open only when idle
    assign ar_ready = (state == IDLE);
    assign wr_ready = (state == IDLE) && !ar_valid;         // Closed while a read is offered

    assign rd_go = (state == IDLE) && ar_valid;             // Read wins a tie
    assign wr_go = (state == IDLE) && wr_valid && !ar_valid;

    // Address decode, only place the full address is looked at
    assign acc_addr  = ar_valid ? ar_addr : wr_req.addr;
    assign sram_hit  = (acc_addr & SRAM_MASK) == SRAM_BASE;
    assign clint_hit = (acc_addr & CLINT_MASK) == CLINT_BASE;
    assign acc_local = sram_hit ? (acc_addr & ~SRAM_MASK) : (acc_addr & ~CLINT_MASK);

    // One-cycle device strobe
    assign dev_req   = req_q;
    assign sram_sel  = (state == ACCESS) && (tgt == TGT_SRAM);
    assign clint_sel = (state == ACCESS) && (tgt == TGT_CLINT);

    // Response source from recorded target
    always_comb begin
        case (tgt)
            TGT_SRAM:  dev_rdata = sram_rdata;
            TGT_CLINT: dev_rdata = clint_rdata;
            default:   dev_rdata = '0;                      // Miss reads as zero
        endcase
        dev_resp = (tgt == TGT_NONE) ? RESP_DECERR : RESP_OKAY;
    end

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            tgt     <= TGT_NONE;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_go || wr_go) begin
                        state <= ACCESS;
                        if (sram_hit)
                            tgt <= TGT_SRAM;
                        else if (clint_hit)
                            tgt <= TGT_CLINT;
                        else
                            tgt <= TGT_NONE;
                    end
                end
                ACCESS: state <= req_q.wr ? RESP_WR : RESP_RD;   // Device acted at this edge
                RESP_RD: begin
                    if (!r_valid)
                        r_valid <= 1'b1;                    // Device word now stable
                    else if (r_ready) begin
                        r_valid <= 1'b0;
                        state   <= IDLE;
                    end
                end
                RESP_WR: begin
                    if (!b_valid)
                        b_valid <= 1'b1;
                    else if (b_ready) begin
                        b_valid <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (rd_go) begin
            req_q.wr   <= 1'b0;
            req_q.ofs  <= acc_local[OFS_W+1:2];             // Byte to word offset
            req_q.data <= '0;
            req_q.strb <= '0;
        end else if (wr_go) begin
            req_q.wr   <= 1'b1;
            req_q.ofs  <= acc_local[OFS_W+1:2];
            req_q.data <= wr_req.data;
            req_q.strb <= wr_req.strb;
        end
        if ((state == RESP_RD) && !r_valid) begin
            r_rsp.data <= dev_rdata;                        // Held under back-pressure
            r_rsp.resp <= dev_resp;
        end
        if ((state == RESP_WR) && !b_valid)
            b_resp <= dev_resp;
    end

endmodule

/* logic/soc_pkg.sv */
package soc_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;                    // One strobe per byte
    localparam int RESP_W = 2;
    localparam int OFS_W  = 16;                            // Word offset seen by devices

    // Response codes, AXI encoding
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    // Address map
    localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] SRAM_MASK  = 32'hF000_0000;   // 256 MB window, aliased
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'hA000_0040;
    localparam logic [ADDR_W-1:0] CLINT_MASK = 32'hFFFF_FFF0;   // 16 bytes, four words

    // Timer register word offsets
    localparam logic [OFS_W-1:0] MTIME_LO_OFS    = 16'd0;
    localparam logic [OFS_W-1:0] MTIME_HI_OFS    = 16'd1;
    localparam logic [OFS_W-1:0] MTIMECMP_LO_OFS = 16'd2;
    localparam logic [OFS_W-1:0] MTIMECMP_HI_OFS = 16'd3;

    // Master write request, address and data in one beat
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                            // Byte address
        logic [DATA_W-1:0] data;                            // Write word
        logic [STRB_W-1:0] strb;                            // Byte enables
    } wr_req_t;

    // Read response payload
    typedef struct packed {
        logic [DATA_W-1:0] data;                            // Read word, 0 on DECERR
        logic [RESP_W-1:0] resp;                            // OKAY or DECERR
    } rd_rsp_t;

    // Request the controller presents to the selected device
    typedef struct packed {
        logic              wr;                              // 1 write, 0 read
        logic [OFS_W-1:0]  ofs;                             // Word offset in region
        logic [DATA_W-1:0] data;                            // Write word
        logic [STRB_W-1:0] strb;                            // Byte enables
    } dev_req_t;

endpackage
